//--- prk_top.f
+incdir+include
hw/prk_pkg.sv
hw/prk_ucode_decode.sv
hw/prk_xb_tracker.sv
hw/prk_cmi_cycle.sv
hw/prk_ma_steer.sv
hw/prk_top.sv
test/prk_tb.sv

//--- test/prk_tb.sv
`timescale 1ns/1ns
`include "prk_defines.svh"

module prk_tb
    import prk_pkg::*;
;

    logic       b_clk = 1'b0;
    logic       rst;
    logic       m_clk_en = 1'b0;
    logic       d_clk_en = 1'b0;
    logic       phase_1;
    bus_code_t  bus_field;
    wctrl_t     wctrl;
    msrc_t      msrc;
    logic       dst_rmode;
    logic [1:0] isize;
    logic       utrap;
    logic       status_valid = 1'b0;
    logic       prefetch;
    logic       cyc_in_prog;
    logic       stall;
    ma_sel_t    ma_select;
    logic       xb_select;
    logic [1:0] xb_in_use;
    logic       ena_pc;

    int          checks = 0;
    int          errors = 0;
    string       test_name = "reset";
    logic [15:0] stim_lfsr = 16'd11;
    logic [15:0] resp_lfsr = 16'd11;
    logic        resp_armed;
    int          resp_cnt;

    prk_top prk_top_inst (.*);

    always #20 b_clk = ~b_clk;

    // Microstep strobe every second cycle
    always @(posedge b_clk) begin
        if (rst) begin
            m_clk_en <= 1'b0;
            d_clk_en <= 1'b0;
        end else begin
            m_clk_en <= ~m_clk_en;
            d_clk_en <= m_clk_en;
        end
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(inout logic [15:0] st, input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            st = lfsr_next(st);
            v  = (v << 1) | st[0];
        end
    endtask

    // ------------------------------------------------------------
    // Memory responder
    // ------------------------------------------------------------
    always @(posedge b_clk) begin
        if (rst || status_valid) begin
            status_valid <= 1'b0;
            resp_armed = 1'b0;
        end else if (cyc_in_prog && !resp_armed) begin
            resp_armed = 1'b1;
            take_bits(resp_lfsr, 2, resp_cnt);  // 1 to 4 cycles
            if (resp_cnt == 0) status_valid <= 1'b1;
        end else if (resp_armed) begin
            resp_cnt = resp_cnt - 1;
            if (resp_cnt == 0) status_valid <= 1'b1;
        end
    end

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    bus_code_t  m_bus;
    logic [1:0] m_loaded;
    logic       m_sel;
    cyc_kind_t  m_kind;
    logic       m_abort;
    logic       m_mdr;
    ma_sel_t    m_ma;
    logic       e_bcyc, e_bread, e_dpc, e_xr, e_busy, e_pf, e_start, e_end;
    logic       e_consume, e_stall, e_ena;

    always_comb begin
        e_bread   = (m_bus[4:3] == 2'b01) || (m_bus == `PRK_BUS_GRANT);
        e_bcyc    = e_bread || (m_bus[4:3] == 2'b10)
                  || (m_bus == `PRK_BUS_WRITE_NOREG && !dst_rmode);
        e_dpc     = (wctrl == `PRK_WCTRL_PC_A) || (wctrl == `PRK_WCTRL_PC_B);
        e_xr      = phase_1 && msrc == `PRK_MSRC_XB && isize != 2'd0;
        e_busy    = (m_kind != CYC_IDLE);
        e_pf      = !rst && m_loaded != 2'b11 && !e_busy && !e_bcyc && !utrap;
        e_start   = m_clk_en && !e_busy && (e_bcyc || e_pf);
        e_end     = e_busy && status_valid;
        e_consume = m_clk_en && e_xr && m_loaded[m_sel];
        e_stall   = (e_xr && !m_loaded[m_sel]) || (e_bcyc && e_busy)
                  || (msrc == `PRK_MSRC_MDR && !m_mdr);
        e_ena     = m_clk_en && !utrap && (e_xr || e_dpc);
    end

    always @(posedge b_clk) begin
        logic [1:0] nxt;
        nxt = m_loaded;
        if (e_consume) nxt[m_sel] = 1'b0;
        if (e_end && m_kind == CYC_PREFETCH && !m_abort) begin
            if (!m_loaded[m_sel]) nxt[m_sel] = 1'b1;
            else nxt[~m_sel] = 1'b1;
        end
        if (e_dpc && m_clk_en) nxt = 2'b00;
        if (rst) begin
            m_bus    <= `PRK_BUS_NOP;
            m_loaded <= 2'b00;
            m_sel    <= 1'b0;
            m_kind   <= CYC_IDLE;
            m_abort  <= 1'b0;
            m_mdr    <= 1'b0;
            m_ma     <= MA_SEL_VA;
        end else begin
            if (m_clk_en) m_bus <= bus_field;
            if (e_end) m_kind <= CYC_IDLE;
            else if (e_start) m_kind <= !e_bcyc ? CYC_PREFETCH : e_bread ? CYC_READ : CYC_WRITE;
            if (e_end) m_abort <= 1'b0;
            else if (e_dpc && m_clk_en && m_kind == CYC_PREFETCH) m_abort <= 1'b1;
            if (e_end && m_kind == CYC_READ) m_mdr <= 1'b1;
            else if (e_start && e_bcyc && e_bread) m_mdr <= 1'b0;
            m_loaded <= nxt;
            if (e_consume) m_sel <= ~m_sel;
            if (phase_1 && msrc[4:2] == 3'b110) m_ma <= ma_sel_t'(msrc[1:0]);
            else m_ma <= e_pf ? MA_SEL_PC : MA_SEL_VA;
        end
    end

    task automatic check(input string what, input logic [7:0] exp, input logic [7:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("error %s %s expected %0h actual %0h", test_name, what, exp, act);
        end
    endtask

    // Outputs settle by the falling edge
    always @(negedge b_clk) begin
        check("cyc_in_prog", m_kind != CYC_IDLE, cyc_in_prog);
        check("prefetch", e_pf, prefetch);
        check("stall", e_stall, stall);
        check("xb_in_use", m_loaded, xb_in_use);
        check("xb_select", m_sel, xb_select);
        check("ma_select", m_ma, ma_select);
        check("ena_pc", e_ena, ena_pc);
    end

    // ------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------
    task automatic ustep(input bus_code_t b, input wctrl_t w, input msrc_t m,
                         input logic [1:0] sz, input logic ph);
        @(posedge b_clk);
        bus_field <= b;
        wctrl     <= w;
        msrc      <= m;
        isize     <= sz;
        phase_1   <= ph;
        @(posedge b_clk);
    endtask

    task automatic stop_on_timeout(input string what);
        errors++;
        $display("timeout in %s while waiting for %s", test_name, what);
        $display("checks %0d errors %0d", checks, errors);
        $display("STATUS: FAIL");
        $finish;
    endtask

    task automatic wait_full(input int limit);
        int n;
        n = 0;
        while (xb_in_use != 2'b11 && n < limit) begin
            @(negedge b_clk);
            n++;
        end
        if (xb_in_use != 2'b11) stop_on_timeout("both buffers to load");
    endtask

    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        while (cyc_in_prog && n < limit) begin
            @(negedge b_clk);
            n++;
        end
        if (cyc_in_prog) stop_on_timeout("the memory cycle to end");
    endtask

    initial begin
        int rb, rk, rs;
        msrc_t rm;
        rst = 1'b1;
        phase_1 = 1'b0;
        bus_field = `PRK_BUS_NOP;
        wctrl = '0;
        msrc = '0;
        dst_rmode = 1'b0;
        isize = 2'd0;
        utrap = 1'b0;
        for (int i = 0; i < 4; i++) @(posedge b_clk);
        rst <= 1'b0;

        test_name = "prefetch_fill";
        wait_full(200);
        repeat (3) ustep(`PRK_BUS_NOP, '0, '0, 2'd0, 1'b0);

        test_name = "consume";
        repeat (5) ustep(`PRK_BUS_NOP, '0, `PRK_MSRC_XB, 2'd1, 1'b1);
        ustep(`PRK_BUS_NOP, `PRK_WCTRL_PC_A, '0, 2'd0, 1'b0);
        ustep(`PRK_BUS_NOP, '0, `PRK_MSRC_XB, 2'd2, 1'b1);    // Empty buffer, must stall
        ustep(`PRK_BUS_NOP, '0, '0, 2'd0, 1'b0);

        test_name = "pc_load";
        for (int t = 0; t < 8; t++) begin
            wait_full(200);
            ustep(`PRK_BUS_NOP, '0, `PRK_MSRC_XB, 2'd3, 1'b1);
            take_bits(stim_lfsr, 1, rb);
            if (rb != 0) ustep(`PRK_BUS_NOP, '0, '0, 2'd0, 1'b0);
            ustep(`PRK_BUS_NOP, t[0] ? `PRK_WCTRL_PC_B : `PRK_WCTRL_PC_A, '0, 2'd0, 1'b0);
            ustep(`PRK_BUS_NOP, '0, '0, 2'd0, 1'b0);
        end

        test_name = "bus_cycles";
        wait_full(200);
        take_bits(stim_lfsr, 3, rb);
        ustep(bus_code_t'(`PRK_BUS_READ_LO + rb), '0, '0, 2'd0, 1'b0);
        ustep(`PRK_BUS_NOP, '0, `PRK_MSRC_MDR, 2'd0, 1'b0);
        repeat (2) ustep(`PRK_BUS_NOP, '0, `PRK_MSRC_MDR, 2'd0, 1'b0);
        wait_idle(50);
        ustep(`PRK_BUS_WRITE_LO, '0, '0, 2'd0, 1'b0);
        ustep(bus_code_t'(`PRK_BUS_WRITE_LO + 4), '0, '0, 2'd0, 1'b0);  // CMI busy
        ustep(`PRK_BUS_NOP, '0, '0, 2'd0, 1'b0);
        wait_idle(50);
        @(posedge b_clk);
        dst_rmode <= 1'b1;
        ustep(`PRK_BUS_WRITE_NOREG, '0, '0, 2'd0, 1'b0);
        ustep(`PRK_BUS_NOP, '0, '0, 2'd0, 1'b0);
        dst_rmode <= 1'b0;
        ustep(`PRK_BUS_WRITE_NOREG, '0, '0, 2'd0, 1'b0);
        repeat (2) ustep(`PRK_BUS_NOP, '0, '0, 2'd0, 1'b0);
        wait_idle(50);
        ustep(`PRK_BUS_GRANT, '0, '0, 2'd0, 1'b0);
        ustep(`PRK_BUS_NOP, '0, `PRK_MSRC_MDR, 2'd0, 1'b0);
        wait_idle(50);

        test_name = "ma_steer";
        for (int k = 0; k < 4; k++) begin
            ustep(`PRK_BUS_NOP, '0, msrc_t'(`PRK_MSRC_MA_LO + k), 2'd0, 1'b1);
        end
        utrap <= 1'b1;
        ustep(`PRK_BUS_NOP, `PRK_WCTRL_PC_B, '0, 2'd0, 1'b0);
        repeat (4) ustep(`PRK_BUS_NOP, '0, `PRK_MSRC_XB, 2'd1, 1'b1);
        utrap <= 1'b0;
        ustep(`PRK_BUS_NOP, '0, '0, 2'd0, 1'b0);

        test_name = "random";
        for (int n = 0; n < 48; n++) begin
            take_bits(stim_lfsr, 5, rb);
            take_bits(stim_lfsr, 3, rk);
            take_bits(stim_lfsr, 2, rs);
            case (rk)
                0: rm = `PRK_MSRC_MDR;
                1, 2: rm = `PRK_MSRC_XB;
                3: rm = msrc_t'(`PRK_MSRC_MA_LO + rs);
                default: rm = '0;
            endcase
            ustep(bus_code_t'(rb), (rk == 7) ? `PRK_WCTRL_PC_B : '0, rm, rs[1:0], 1'b1);
        end
        ustep(`PRK_BUS_NOP, '0, '0, 2'd0, 1'b0);
        @(negedge b_clk);

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- hw/prk_top.sv
`timescale 1ns/1ns

module prk_top
    import prk_pkg::*;
(
    input  logic       b_clk,
    input  logic       rst,
    input  logic       m_clk_en,
    input  logic       d_clk_en,
    input  logic       phase_1,

    input  bus_code_t  bus_field,
    input  wctrl_t     wctrl,
    input  msrc_t      msrc,
    input  logic       dst_rmode,
    input  logic [1:0] isize,
    input  logic       utrap,
    input  logic       status_valid,

    output logic       prefetch,
    output logic       cyc_in_prog,
    output logic       stall,
    output ma_sel_t    ma_select,
    output logic       xb_select,
    output logic [1:0] xb_in_use,
    output logic       ena_pc
);

    logic bus_cyc;
    logic bus_read;
    logic dest_pc;
    logic load_pc;
    logic xb_req;
    logic mdr_src;
    logic ma_src;
    logic xb_stall;
    logic flush;
    logic fill;

    prk_ucode_decode prk_ucode_decode_inst (
        .b_clk     (b_clk),
        .rst       (rst),
        .m_clk_en  (m_clk_en),
        .bus_field (bus_field),
        .wctrl     (wctrl),
        .msrc      (msrc),
        .dst_rmode (dst_rmode),
        .phase_1   (phase_1),
        .isize     (isize),
        .bus_cyc   (bus_cyc),
        .bus_read  (bus_read),
        .dest_pc   (dest_pc),
        .load_pc   (load_pc),
        .xb_req    (xb_req),
        .mdr_src   (mdr_src),
        .ma_src    (ma_src)
    );

    prk_xb_tracker prk_xb_tracker_inst (
        .b_clk     (b_clk),
        .rst       (rst),
        .m_clk_en  (m_clk_en),
        .utrap     (utrap),
        .xb_req    (xb_req),
        .dest_pc   (dest_pc),
        .load_pc   (load_pc),
        .fill      (fill),
        .xb_loaded (xb_in_use),
        .xb_select (xb_select),
        .xb_stall  (xb_stall),
        .ena_pc    (ena_pc),
        .flush     (flush)
    );

    prk_cmi_cycle prk_cmi_cycle_inst (
        .b_clk        (b_clk),
        .rst          (rst),
        .m_clk_en     (m_clk_en),
        .status_valid (status_valid),
        .utrap        (utrap),
        .bus_cyc      (bus_cyc),
        .bus_read     (bus_read),
        .mdr_src      (mdr_src),
        .flush        (flush),
        .xb_stall     (xb_stall),
        .xb_loaded    (xb_in_use),
        .prefetch     (prefetch),
        .fill         (fill),
        .cyc_in_prog  (cyc_in_prog),
        .stall        (stall)
    );

    prk_ma_steer prk_ma_steer_inst (
        .b_clk     (b_clk),
        .rst       (rst),
        .phase_1   (phase_1),
        .ma_src    (ma_src),
        .msrc      (msrc),
        .prefetch  (prefetch),
        .ma_select (ma_select)
    );

endmodule

//--- hw/prk_ma_steer.sv
`timescale 1ns/1ns

module prk_ma_steer
    import prk_pkg::*;
(
    input  logic    b_clk,
    input  logic    rst,
    input  logic    phase_1,
    input  logic    ma_src,
    input  msrc_t   msrc,
    input  logic    prefetch,

    output ma_sel_t ma_select
);

    ma_sel_t sel_nxt;

    // ------------------------------------------------------------
    // MA mux select, microcode first, then prefetch
    // ------------------------------------------------------------
    always_comb begin
        if (phase_1 && ma_src) begin
            sel_nxt = ma_sel_t'(msrc[1:0]);
        end else if (prefetch) begin
            sel_nxt = MA_SEL_PC;    // Prefetch reads at PC
        end else begin
            sel_nxt = MA_SEL_VA;
        end
    end

    always_ff @(posedge b_clk) begin
        if (rst) begin
            ma_select <= MA_SEL_VA;
        end else begin
            ma_select <= sel_nxt;
        end
    end

endmodule

//--- hw/prk_cmi_cycle.sv
`timescale 1ns/1ns

module prk_cmi_cycle
    import prk_pkg::*;
(
    input  logic       b_clk,
    input  logic       rst,
    input  logic       m_clk_en,
    input  logic       status_valid,
    input  logic       utrap,

    input  logic       bus_cyc,
    input  logic       bus_read,
    input  logic       mdr_src,

    input  logic       flush,
    input  logic       xb_stall,
    input  logic [1:0] xb_loaded,

    output logic       prefetch,
    output logic       fill,
    output logic       cyc_in_prog,
    output logic       stall
);

    cyc_kind_t cyc_kind;
    logic      aborted;     // PC reload hit a prefetch in flight
    logic      mdr_loaded;

    logic      cyc_start;
    logic      cyc_end;
    logic      prefetch_cyc;
    cyc_kind_t start_kind;

    assign cyc_in_prog  = (cyc_kind != CYC_IDLE);
    assign prefetch_cyc = (cyc_kind == CYC_PREFETCH);

    // ------------------------------------------------------------
    // Prefetch request
    // ------------------------------------------------------------
    assign prefetch = ~rst & ~(&xb_loaded) & ~cyc_in_prog & ~bus_cyc & ~utrap;

    assign cyc_start = m_clk_en & ~cyc_in_prog & (bus_cyc | prefetch);
    assign cyc_end   = cyc_in_prog & status_valid;

    // Microcode cycle wins over prefetch
    always_comb begin
        if (bus_cyc) begin
            start_kind = bus_read ? CYC_READ : CYC_WRITE;
        end else begin
            start_kind = CYC_PREFETCH;
        end
    end

    // ------------------------------------------------------------
    // Cycle state
    // ------------------------------------------------------------
    always_ff @(posedge b_clk) begin
        if (rst) begin
            cyc_kind <= CYC_IDLE;
        end else if (cyc_end) begin
            cyc_kind <= CYC_IDLE;
        end else if (cyc_start) begin
            cyc_kind <= start_kind;
        end
    end

    always_ff @(posedge b_clk) begin
        if (rst) begin
            aborted <= 1'b0;
        end else if (cyc_end) begin
            aborted <= 1'b0;
        end else if (flush && prefetch_cyc) begin
            aborted <= 1'b1;
        end
    end

    // Read data sits in MDR until the next read begins
    always_ff @(posedge b_clk) begin
        if (rst) begin
            mdr_loaded <= 1'b0;
        end else if (cyc_end && cyc_kind == CYC_READ) begin
            mdr_loaded <= 1'b1;
        end else if (cyc_start && start_kind == CYC_READ) begin
            mdr_loaded <= 1'b0;
        end
    end

    // Prefetch data returned and still wanted
    assign fill = cyc_end & prefetch_cyc & ~aborted;

    // ------------------------------------------------------------
    // Stall merge
    // ------------------------------------------------------------
    assign stall = xb_stall
                 | (bus_cyc & cyc_in_prog)      // CMI busy
                 | (mdr_src & ~mdr_loaded);     // MDR not there yet

endmodule

//--- hw/prk_xb_tracker.sv
`timescale 1ns/1ns

module prk_xb_tracker (
    input  logic       b_clk,
    input  logic       rst,
    input  logic       m_clk_en,
    input  logic       utrap,

    input  logic       xb_req,
    input  logic       dest_pc,
    input  logic       load_pc,
    input  logic       fill,

    output logic [1:0] xb_loaded,
    output logic       xb_select,
    output logic       xb_stall,
    output logic       ena_pc,
    output logic       flush
);

    logic       sel_loaded;
    logic       consume;
    logic       fill_tgt;   // Buffer that takes the next fill
    logic [1:0] loaded_nxt;

    assign sel_loaded = xb_loaded[xb_select];
    assign consume    = m_clk_en & xb_req & sel_loaded;
    assign fill_tgt   = sel_loaded ? ~xb_select : xb_select;

    // ------------------------------------------------------------
    // Buffer flags
    // ------------------------------------------------------------
    always_comb begin
        loaded_nxt = xb_loaded;
        if (consume) begin
            loaded_nxt[xb_select] = 1'b0;
        end
        if (fill) begin
            loaded_nxt[fill_tgt] = 1'b1;
        end
        if (load_pc) begin
            loaded_nxt = 2'b00;     // New PC, old bytes are stale
        end
    end

    always_ff @(posedge b_clk) begin
        if (rst) begin
            xb_loaded <= 2'b00;
        end else begin
            xb_loaded <= loaded_nxt;
        end
    end

    always_ff @(posedge b_clk) begin
        if (rst) begin
            xb_select <= 1'b0;
        end else if (consume) begin
            xb_select <= ~xb_select;
        end
    end

    // ------------------------------------------------------------
    // Status to the rest of the slice
    // ------------------------------------------------------------
    assign xb_stall = xb_req & ~sel_loaded;
    assign ena_pc   = m_clk_en & ~utrap & (xb_req | dest_pc);
    assign flush    = load_pc;

endmodule

//--- hw/prk_ucode_decode.sv
`timescale 1ns/1ns
`include "prk_defines.svh"

module prk_ucode_decode
    import prk_pkg::*;
(
    input  logic       b_clk,
    input  logic       rst,
    input  logic       m_clk_en,

    input  bus_code_t  bus_field,
    input  wctrl_t     wctrl,
    input  msrc_t      msrc,
    input  logic       dst_rmode,
    input  logic       phase_1,
    input  logic [1:0] isize,

    output logic       bus_cyc,
    output logic       bus_read,
    output logic       dest_pc,
    output logic       load_pc,
    output logic       xb_req,
    output logic       mdr_src,
    output logic       ma_src
);

    bus_code_t bus_q;   // Bus field held for the whole microstep

    // ------------------------------------------------------------
    // Bus field latch
    // ------------------------------------------------------------
    always_ff @(posedge b_clk) begin
        if (rst) begin
            bus_q <= `PRK_BUS_NOP;
        end else if (m_clk_en) begin
            bus_q <= bus_field;
        end
    end

    always_comb begin
        bus_cyc  = 1'b0;
        bus_read = 1'b0;
        if (bus_q >= `PRK_BUS_READ_LO && bus_q <= `PRK_BUS_READ_HI) begin
            bus_cyc  = 1'b1;
            bus_read = 1'b1;
        end else if (bus_q >= `PRK_BUS_WRITE_LO && bus_q <= `PRK_BUS_WRITE_HI) begin
            bus_cyc  = 1'b1;
        end else if (bus_q == `PRK_BUS_WRITE_NOREG) begin
            bus_cyc  = ~dst_rmode;  // Register mode skips memory
        end else if (bus_q == `PRK_BUS_GRANT) begin
            bus_cyc  = 1'b1;
            bus_read = 1'b1;
        end
    end

    // ------------------------------------------------------------
    // Destination and source decode, current microword
    // ------------------------------------------------------------
    assign dest_pc = (wctrl == `PRK_WCTRL_PC_A) || (wctrl == `PRK_WCTRL_PC_B);
    assign load_pc = dest_pc & m_clk_en;

    assign mdr_src = (msrc == `PRK_MSRC_MDR);
    assign ma_src  = (msrc >= `PRK_MSRC_MA_LO) && (msrc <= `PRK_MSRC_MA_HI);

    // Instruction bytes wanted from XB
    assign xb_req = phase_1 & (msrc == `PRK_MSRC_XB) & (|isize);

endmodule

//--- hw/prk_pkg.sv
`include "prk_defines.svh"

package prk_pkg;

    // --------------------------------------------------------
    // Raw microcode fields
    // --------------------------------------------------------
    typedef logic [`PRK_BUS_W-1:0]   bus_code_t;
    typedef logic [`PRK_WCTRL_W-1:0] wctrl_t;
    typedef logic [`PRK_MSRC_W-1:0]  msrc_t;

    // Same order as the low bits of the address msrc group
    typedef enum logic [1:0] {
        MA_SEL_MA     = 2'd0,
        MA_SEL_PCSAVE = 2'd1,
        MA_SEL_PC     = 2'd2,
        MA_SEL_VA     = 2'd3
    } ma_sel_t;

    // Kind of CMI cycle in flight
    typedef enum logic [1:0] {
        CYC_IDLE     = 2'd0,
        CYC_PREFETCH = 2'd1,
        CYC_READ     = 2'd2,
        CYC_WRITE    = 2'd3
    } cyc_kind_t;

endpackage

//--- include/prk_defines.svh
`ifndef PRK_DEFINES_SVH
`define PRK_DEFINES_SVH

// ------------------------------------------------------------
// Microcode field widths
// ------------------------------------------------------------
`define PRK_BUS_W   5
`define PRK_WCTRL_W 6
`define PRK_MSRC_W  5

// ------------------------------------------------------------
// Bus field codes
// ------------------------------------------------------------
`define PRK_BUS_NOP         5'd0

// Probe group, no memory cycle here
`define PRK_BUS_PROBE_LO    5'd1
`define PRK_BUS_PROBE_HI    5'd7

// Read group, bit 3 set
`define PRK_BUS_READ_LO     5'd8
`define PRK_BUS_READ_HI     5'd15

`define PRK_BUS_WRITE_LO    5'd16
`define PRK_BUS_WRITE_HI    5'd23

// Only a cycle when the destination is not a register
`define PRK_BUS_WRITE_NOREG 5'd24

// Counts as a read cycle
`define PRK_BUS_GRANT       5'd31

// ------------------------------------------------------------
// Write-control codes
// ------------------------------------------------------------
`define PRK_WCTRL_PC_A      6'h24
`define PRK_WCTRL_PC_B      6'h2C

// ------------------------------------------------------------
// Memory-source codes
// ------------------------------------------------------------
`define PRK_MSRC_MDR        5'h12
`define PRK_MSRC_XB         5'h17

// Address group, low two bits pick the MA mux input
`define PRK_MSRC_MA_LO      5'h18
`define PRK_MSRC_MA_HI      5'h1B

`endif
